// File: Bender.yml
package:
  name: soc_peripherals

sources:
  # Packages first, then the RTL in dependency order
  - soc_apb_pkg.sv
  - soc_periph_pkg.sv
  - periph_apb_decoder.sv
  - gpio_ctrl.sv
  - soc_ctrl_regs.sv
  - periph_timer.sv
  - fc_event_collector.sv
  - soc_peripherals.sv

  - target: simulation
    files:
      - soc_peripherals_properties.sv
      - tb_soc_peripherals.sv

// File: fc_event_collector.sv
// FC event vector assembly and reference clock edge detection
// slow_clk_i is asynchronous and passes two synchronizer flops
// The event vector is registered, every bit lags its source by one cycle
`timescale 1ns/1ns

module fc_event_collector
    import soc_periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       slow_clk_i,

    input  logic       gpio_irq_i,
    input  logic       timer_irq_i,
    input  logic       dma_pe_evt_i,
    input  logic       dma_pe_irq_i,
    input  logic       pf_evt_i,

    output logic       ref_rise_o,
    output fc_events_t fc_events_o
);

    logic       ref_sync1_q;
    logic       ref_sync2_q;
    logic       ref_last_q;
    logic       ref_fall;
    fc_events_t events_d;
    fc_events_t events_q;

    assign ref_rise_o = ref_sync2_q & ~ref_last_q;
    assign ref_fall   = ~ref_sync2_q & ref_last_q;

    // Unlisted positions stay 0
    always_comb begin
        events_d               = '0;
        events_d[EVT_DMA_PE]   = dma_pe_evt_i;
        events_d[EVT_DMA_IRQ]  = dma_pe_irq_i;
        events_d[EVT_TIMER]    = timer_irq_i;
        events_d[EVT_PF]       = pf_evt_i;
        events_d[EVT_REF_EDGE] = ref_rise_o | ref_fall;
        events_d[EVT_GPIO]     = gpio_irq_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ref_sync1_q <= 1'b0;
            ref_sync2_q <= 1'b0;
            ref_last_q  <= 1'b0;
            events_q    <= '0;
        end else begin
            ref_sync1_q <= slow_clk_i;
            ref_sync2_q <= ref_sync1_q;
            ref_last_q  <= ref_sync2_q;
            events_q    <= events_d;
        end
    end

    assign fc_events_o = events_q;

endmodule

// File: gpio_ctrl.sv
// GPIO block with direction, output and rising-edge interrupt registers
// Pins pass two synchronizer flops before edge detection
// Interrupt status is sticky and clears when read
`timescale 1ns/1ns

module gpio_ctrl
    import soc_apb_pkg::*;
    import soc_periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  logic      sel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  offs_t     offs_i,
    input  pdata_t    pwdata_i,
    output pdata_t    rdata_o,

    input  gpio_vec_t gpio_i,
    output gpio_vec_t gpio_dir_o,
    output gpio_vec_t gpio_out_o,
    output logic      gpio_irq_o
);

    gpio_vec_t in_sync1_q;
    gpio_vec_t in_sync2_q;
    gpio_vec_t in_last_q;
    gpio_vec_t dir_q;
    gpio_vec_t out_q;
    gpio_vec_t ien_q;
    gpio_vec_t ist_q;
    gpio_vec_t rise;
    logic      irq_q;
    logic      wr_en;
    logic      rd_en;

    assign wr_en = sel_i & penable_i & pwrite_i;
    assign rd_en = sel_i & penable_i & ~pwrite_i;

    // Rising edges on enabled pins only
    assign rise = in_sync2_q & ~in_last_q & ien_q;

    ////////////////////////////////////////
    // Input synchronizer and edge flop
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_sync1_q <= '0;
            in_sync2_q <= '0;
            in_last_q  <= '0;
            irq_q      <= 1'b0;
        end else begin
            in_sync1_q <= gpio_i;
            in_sync2_q <= in_sync1_q;
            in_last_q  <= in_sync2_q;
            irq_q      <= |rise;
        end
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q <= '0;
            out_q <= '0;
            ien_q <= '0;
            ist_q <= '0;
        end else begin
            if (wr_en && offs_i == GPIO_DIR_OFFS) dir_q <= pwdata_i;
            if (wr_en && offs_i == GPIO_OUT_OFFS) out_q <= pwdata_i;
            if (wr_en && offs_i == GPIO_IEN_OFFS) ien_q <= pwdata_i;
            // Clear on read, a fresh edge still sets its bit
            if (rd_en && offs_i == GPIO_IST_OFFS) begin
                ist_q <= rise;
            end else begin
                ist_q <= ist_q | rise;
            end
        end
    end

    always_comb begin
        case (offs_i)
            GPIO_DIR_OFFS: rdata_o = dir_q;
            GPIO_OUT_OFFS: rdata_o = out_q;
            GPIO_IN_OFFS:  rdata_o = in_sync2_q;
            GPIO_IEN_OFFS: rdata_o = ien_q;
            GPIO_IST_OFFS: rdata_o = ist_q;
            default:       rdata_o = '0;
        endcase
    end

    assign gpio_dir_o = dir_q;
    assign gpio_out_o = out_q;
    assign gpio_irq_o = irq_q;

endmodule

// File: periph_apb_decoder.sv
// APB region decoder for the three peripheral peers
// Single master, no wait states, pready is tied high
// Unmapped regions raise pslverr in the access cycle and read zero
`timescale 1ns/1ns

module periph_apb_decoder
    import soc_apb_pkg::*;
(
    // Slave port from the fabric controller
    input  paddr_t paddr_i,
    input  logic   psel_i,
    input  logic   penable_i,
    input  logic   pwrite_i,
    input  pdata_t pwdata_i,
    output pdata_t prdata_o,
    output logic   pready_o,
    output logic   pslverr_o,

    // Peer side
    output logic   gpio_sel_o,
    output logic   timer_sel_o,
    output logic   soc_sel_o,
    output offs_t  offs_o,
    output logic   penable_o,
    output logic   pwrite_o,
    output pdata_t pwdata_o,
    input  pdata_t gpio_rdata_i,
    input  pdata_t timer_rdata_i,
    input  pdata_t soc_rdata_i
);

    logic [REGION_MSB-REGION_LSB:0] region;
    logic gpio_hit;
    logic timer_hit;
    logic soc_hit;

    assign region    = paddr_i[REGION_MSB:REGION_LSB];
    assign gpio_hit  = (region == GPIO_BASE[REGION_MSB:REGION_LSB]);
    assign timer_hit = (region == TIMER_BASE[REGION_MSB:REGION_LSB]);
    assign soc_hit   = (region == SOC_CTRL_BASE[REGION_MSB:REGION_LSB]);

    // One select per peer
    assign gpio_sel_o  = psel_i & gpio_hit;
    assign timer_sel_o = psel_i & timer_hit;
    assign soc_sel_o   = psel_i & soc_hit;

    // Shared strobes and data go to every peer
    assign offs_o    = paddr_i[OFFS_WIDTH-1:0];
    assign penable_o = penable_i;
    assign pwrite_o  = pwrite_i;
    assign pwdata_o  = pwdata_i;

    // Read data back from the addressed peer
    always_comb begin
        if (gpio_hit) begin
            prdata_o = gpio_rdata_i;
        end else if (timer_hit) begin
            prdata_o = timer_rdata_i;
        end else if (soc_hit) begin
            prdata_o = soc_rdata_i;
        end else begin
            prdata_o = '0;
        end
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i & penable_i & ~(gpio_hit | timer_hit | soc_hit);

endmodule

// File: periph_timer.sv
// Compare timer counting clock cycles or reference clock rising edges
// On a tick with count equal to compare the count wraps to 0 and irq pulses
// An APB count write wins over a tick in the same cycle
`timescale 1ns/1ns

module periph_timer
    import soc_apb_pkg::*;
    import soc_periph_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,

    input  logic   sel_i,
    input  logic   penable_i,
    input  logic   pwrite_i,
    input  offs_t  offs_i,
    input  pdata_t pwdata_i,
    output pdata_t rdata_o,

    input  logic   ref_rise_i,
    output logic   timer_irq_o
);

    logic [TIMER_CTRL_WIDTH-1:0] ctrl_q;
    timer_cnt_t                  cnt_q;
    timer_cnt_t                  cmp_q;
    logic                        irq_q;
    logic                        wr_en;
    logic                        tick;
    logic                        match;

    assign wr_en = sel_i & penable_i & pwrite_i;

    // Count source selects every clock or the reference rising edge
    assign tick  = ctrl_q[TIMER_EN_BIT] & (ctrl_q[TIMER_REF_SRC_BIT] ? ref_rise_i : 1'b1);
    assign match = (cnt_q == cmp_q);

    ////////////////////////////////////////
    // Control and compare
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
            cmp_q  <= '0;
        end else begin
            if (wr_en && offs_i == TIMER_CTRL_OFFS) ctrl_q <= pwdata_i[TIMER_CTRL_WIDTH-1:0];
            if (wr_en && offs_i == TIMER_CMP_OFFS)  cmp_q  <= pwdata_i;
        end
    end

    ////////////////////////////////////////
    // Counter
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            irq_q <= 1'b0;
        end else begin
            if (wr_en && offs_i == TIMER_CNT_OFFS) begin
                cnt_q <= pwdata_i;
            end else if (tick) begin
                cnt_q <= match ? '0 : cnt_q + 1'b1;
            end
            irq_q <= tick & match;
        end
    end

    always_comb begin
        case (offs_i)
            TIMER_CTRL_OFFS: rdata_o = pdata_t'(ctrl_q);
            TIMER_CNT_OFFS:  rdata_o = cnt_q;
            TIMER_CMP_OFFS:  rdata_o = cmp_q;
            default:         rdata_o = '0;
        endcase
    end

    assign timer_irq_o = irq_q;

endmodule

// File: sim.f
soc_apb_pkg.sv
soc_periph_pkg.sv
periph_apb_decoder.sv
gpio_ctrl.sv
soc_ctrl_regs.sv
periph_timer.sv
fc_event_collector.sv
soc_peripherals.sv
soc_peripherals_properties.sv
tb_soc_peripherals.sv

// File: soc_apb_pkg.sv
// APB widths, peripheral address map and register offsets
// Regions are 4 KiB wide and only address bits 15 to 12 are decoded
// Upper address bits are ignored so the map repeats every 64 KiB
package soc_apb_pkg;

    localparam int unsigned APB_ADDR_WIDTH = 32;
    localparam int unsigned APB_DATA_WIDTH = 32;
    localparam int unsigned OFFS_WIDTH     = 12;

    typedef logic [APB_ADDR_WIDTH-1:0] paddr_t;
    typedef logic [APB_DATA_WIDTH-1:0] pdata_t;
    typedef logic [OFFS_WIDTH-1:0]     offs_t;

    // Region field of the address
    localparam int unsigned REGION_LSB = OFFS_WIDTH;
    localparam int unsigned REGION_MSB = 15;

    localparam paddr_t GPIO_BASE     = 32'h0000_0000;
    localparam paddr_t TIMER_BASE    = 32'h0000_1000;
    localparam paddr_t SOC_CTRL_BASE = 32'h0000_2000;

    // GPIO registers
    localparam offs_t GPIO_DIR_OFFS = 12'h000;
    localparam offs_t GPIO_OUT_OFFS = 12'h004;
    localparam offs_t GPIO_IN_OFFS  = 12'h008;
    localparam offs_t GPIO_IEN_OFFS = 12'h00C;
    localparam offs_t GPIO_IST_OFFS = 12'h010;

    // Timer registers
    localparam offs_t TIMER_CTRL_OFFS = 12'h000;
    localparam offs_t TIMER_CNT_OFFS  = 12'h004;
    localparam offs_t TIMER_CMP_OFFS  = 12'h008;

    // SoC control registers
    localparam offs_t SOC_BOOT_OFFS  = 12'h000;
    localparam offs_t SOC_FETCH_OFFS = 12'h004;
    localparam offs_t SOC_INFO_OFFS  = 12'h008;

endpackage

// File: soc_ctrl_regs.sv
// SoC control registers for the FC boot address and fetch enable
// The fetch enable strobe pin overrides an APB write in the same cycle
// Info register is read only and returns the core count
`timescale 1ns/1ns

module soc_ctrl_regs
    import soc_apb_pkg::*;
    import soc_periph_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,

    input  logic   sel_i,
    input  logic   penable_i,
    input  logic   pwrite_i,
    input  offs_t  offs_i,
    input  pdata_t pwdata_i,
    output pdata_t rdata_o,

    input  logic   fc_fetch_en_valid_i,
    input  logic   fc_fetch_en_i,
    output pdata_t fc_bootaddr_o,
    output logic   fc_fetchen_o
);

    pdata_t boot_q;
    logic   fetch_q;
    logic   wr_en;

    assign wr_en = sel_i & penable_i & pwrite_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            boot_q  <= BOOT_ADDR_DEFAULT;
            fetch_q <= 1'b0;
        end else begin
            if (wr_en && offs_i == SOC_BOOT_OFFS) begin
                boot_q <= pwdata_i;
            end
            // Pin strobe has priority over the bus
            if (fc_fetch_en_valid_i) begin
                fetch_q <= fc_fetch_en_i;
            end else if (wr_en && offs_i == SOC_FETCH_OFFS) begin
                fetch_q <= pwdata_i[0];
            end
        end
    end

    always_comb begin
        case (offs_i)
            SOC_BOOT_OFFS:  rdata_o = boot_q;
            SOC_FETCH_OFFS: rdata_o = pdata_t'(fetch_q);
            SOC_INFO_OFFS:  rdata_o = pdata_t'(NB_CORES_INFO);
            default:        rdata_o = '0;
        endcase
    end

    assign fc_bootaddr_o = boot_q;
    assign fc_fetchen_o  = fetch_q;

endmodule

// File: soc_periph_pkg.sv
// Peripheral widths, FC event bit positions and reset values
// GPIO_NUM must equal the APB data width, one pin per register bit
// Event positions follow the fabric controller event map
package soc_periph_pkg;

    localparam int unsigned GPIO_NUM = 32;
    typedef logic [GPIO_NUM-1:0] gpio_vec_t;

    localparam int unsigned EVT_NUM = 32;
    typedef logic [EVT_NUM-1:0] fc_events_t;

    // FC event vector positions
    localparam int unsigned EVT_DMA_PE   = 8;
    localparam int unsigned EVT_DMA_IRQ  = 9;
    localparam int unsigned EVT_TIMER    = 10;
    localparam int unsigned EVT_PF       = 12;
    localparam int unsigned EVT_REF_EDGE = 14;
    localparam int unsigned EVT_GPIO     = 15;

    // Boot and info values
    localparam logic [31:0] BOOT_ADDR_DEFAULT = 32'h1C00_8080;
    localparam int unsigned NB_CORES_INFO     = 4;

    // Timer
    localparam int unsigned TIMER_CNT_WIDTH = 32;
    typedef logic [TIMER_CNT_WIDTH-1:0] timer_cnt_t;

    localparam int unsigned TIMER_CTRL_WIDTH  = 2;
    localparam int unsigned TIMER_EN_BIT      = 0;
    localparam int unsigned TIMER_REF_SRC_BIT = 1;

endpackage

// File: soc_peripherals.sv
// SoC peripheral subsystem with one APB slave port and three peers
// Peers are GPIO, compare timer and SoC control, behind a region decoder
// APB transfers take two cycles with no wait states
`timescale 1ns/1ns

module soc_peripherals
    import soc_apb_pkg::*;
    import soc_periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       slow_clk_i,

    // APB slave port
    input  paddr_t     paddr_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  pdata_t     pwdata_i,
    output pdata_t     prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,

    // GPIO pins
    input  gpio_vec_t  gpio_i,
    output gpio_vec_t  gpio_dir_o,
    output gpio_vec_t  gpio_out_o,

    // Fetch enable override
    input  logic       fc_fetch_en_valid_i,
    input  logic       fc_fetch_en_i,
    output pdata_t     fc_bootaddr_o,
    output logic       fc_fetchen_o,

    // Events
    input  logic       dma_pe_evt_i,
    input  logic       dma_pe_irq_i,
    input  logic       pf_evt_i,
    output fc_events_t fc_events_o
);

    logic   gpio_sel;
    logic   timer_sel;
    logic   soc_sel;
    offs_t  per_offs;
    logic   per_penable;
    logic   per_pwrite;
    pdata_t per_pwdata;
    pdata_t gpio_rdata;
    pdata_t timer_rdata;
    pdata_t soc_rdata;
    logic   gpio_irq;
    logic   timer_irq;
    logic   ref_rise;

    ////////////////////////////////////////
    // APB decoder
    ////////////////////////////////////////
    periph_apb_decoder u_decoder (
        .paddr_i       ( paddr_i     ),
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .pwdata_i      ( pwdata_i    ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   ),
        .gpio_sel_o    ( gpio_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .soc_sel_o     ( soc_sel     ),
        .offs_o        ( per_offs    ),
        .penable_o     ( per_penable ),
        .pwrite_o      ( per_pwrite  ),
        .pwdata_o      ( per_pwdata  ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .soc_rdata_i   ( soc_rdata   )
    );

    ////////////////////////////////////////
    // Peers
    ////////////////////////////////////////
    gpio_ctrl u_gpio (
        .clk_i      ( clk_i       ),
        .rst_n_i    ( rst_n_i     ),
        .sel_i      ( gpio_sel    ),
        .penable_i  ( per_penable ),
        .pwrite_i   ( per_pwrite  ),
        .offs_i     ( per_offs    ),
        .pwdata_i   ( per_pwdata  ),
        .rdata_o    ( gpio_rdata  ),
        .gpio_i     ( gpio_i      ),
        .gpio_dir_o ( gpio_dir_o  ),
        .gpio_out_o ( gpio_out_o  ),
        .gpio_irq_o ( gpio_irq    )
    );

    soc_ctrl_regs u_soc_ctrl (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .sel_i               ( soc_sel             ),
        .penable_i           ( per_penable         ),
        .pwrite_i            ( per_pwrite          ),
        .offs_i              ( per_offs            ),
        .pwdata_i            ( per_pwdata          ),
        .rdata_o             ( soc_rdata           ),
        .fc_fetch_en_valid_i ( fc_fetch_en_valid_i ),
        .fc_fetch_en_i       ( fc_fetch_en_i       ),
        .fc_bootaddr_o       ( fc_bootaddr_o       ),
        .fc_fetchen_o        ( fc_fetchen_o        )
    );

    periph_timer u_timer (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .sel_i       ( timer_sel   ),
        .penable_i   ( per_penable ),
        .pwrite_i    ( per_pwrite  ),
        .offs_i      ( per_offs    ),
        .pwdata_i    ( per_pwdata  ),
        .rdata_o     ( timer_rdata ),
        .ref_rise_i  ( ref_rise    ),
        .timer_irq_o ( timer_irq   )
    );

    ////////////////////////////////////////
    // FC events
    ////////////////////////////////////////
    fc_event_collector u_events (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .slow_clk_i   ( slow_clk_i   ),
        .gpio_irq_i   ( gpio_irq     ),
        .timer_irq_i  ( timer_irq    ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .ref_rise_o   ( ref_rise     ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

// File: soc_peripherals_properties.sv
// Concurrent checks bound to the peripheral top level
// All checks except the fetch enable one are disabled while in reset
`timescale 1ns/1ns

module soc_peripherals_properties
    import soc_periph_pkg::*;
(
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       psel_i,
    input logic       penable_i,
    input logic       pready_i,
    input logic       pslverr_i,
    input logic       fc_fetchen_i,
    input fc_events_t fc_events_i
);

    // Positions that the collector drives
    localparam fc_events_t EVT_USED = fc_events_t'((1 << EVT_DMA_PE) | (1 << EVT_DMA_IRQ) |
        (1 << EVT_TIMER) | (1 << EVT_PF) | (1 << EVT_REF_EDGE) | (1 << EVT_GPIO));

    int unsigned fail_count = 0;

    a_pready_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_i && penable_i |-> pready_i)
        else begin
            $error("pready low in an APB access cycle");
            fail_count++;
        end

    a_events_unused_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (fc_events_i & ~EVT_USED) == '0)
        else begin
            $error("fc_events_o has a bit set outside the event positions");
            fail_count++;
        end

    a_fetchen_reset: assert property (@(posedge clk_i) !rst_n_i |-> !fc_fetchen_i)
        else begin
            $error("fc_fetchen_o high during reset");
            fail_count++;
        end

    a_pslverr_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pslverr_i |-> psel_i && penable_i)
        else begin
            $error("pslverr high outside an APB access cycle");
            fail_count++;
        end

endmodule

// File: tb_soc_peripherals.sv
// Testbench for the SoC peripheral subsystem
// Stimulus changes on the falling edge
// Read data is sampled inside the access cycle
`timescale 1ns/1ns

module tb_soc_peripherals
    import soc_apb_pkg::*;
    import soc_periph_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       slow_clk;
    paddr_t     paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    pdata_t     pwdata;
    pdata_t     prdata;
    logic       pready;
    logic       pslverr;
    gpio_vec_t  gpio_in;
    gpio_vec_t  gpio_dir;
    gpio_vec_t  gpio_out;
    logic       fetch_valid;
    logic       fetch_en;
    pdata_t     bootaddr;
    logic       fetchen;
    logic       dma_pe_evt;
    logic       dma_pe_irq;
    logic       pf_evt;
    fc_events_t events;

    integer      seed = 6;
    int unsigned cycle_cnt = 0;

    soc_peripherals u_soc_peripherals (
        .clk_i               ( clk         ),
        .rst_n_i             ( rst_n       ),
        .slow_clk_i          ( slow_clk    ),
        .paddr_i             ( paddr       ),
        .psel_i              ( psel        ),
        .penable_i           ( penable     ),
        .pwrite_i            ( pwrite      ),
        .pwdata_i            ( pwdata      ),
        .prdata_o            ( prdata      ),
        .pready_o            ( pready      ),
        .pslverr_o           ( pslverr     ),
        .gpio_i              ( gpio_in     ),
        .gpio_dir_o          ( gpio_dir    ),
        .gpio_out_o          ( gpio_out    ),
        .fc_fetch_en_valid_i ( fetch_valid ),
        .fc_fetch_en_i       ( fetch_en    ),
        .fc_bootaddr_o       ( bootaddr    ),
        .fc_fetchen_o        ( fetchen     ),
        .dma_pe_evt_i        ( dma_pe_evt  ),
        .dma_pe_irq_i        ( dma_pe_irq  ),
        .pf_evt_i            ( pf_evt      ),
        .fc_events_o         ( events      )
    );

    bind soc_peripherals soc_peripherals_properties u_props (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .psel_i       ( psel_i       ),
        .penable_i    ( penable_i    ),
        .pready_i     ( pready_o     ),
        .pslverr_i    ( pslverr_o    ),
        .fc_fetchen_i ( fc_fetchen_o ),
        .fc_events_i  ( fc_events_o  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    always @(negedge clk) begin
        if (u_soc_peripherals.u_props.fail_count != 0) begin
            $display("TESTS FAILED");
            $fatal(1, "bound assertion failed");
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic apb_write(input paddr_t addr, input pdata_t data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input paddr_t addr, output pdata_t data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Returns at the falling edge where the event bit is seen high
    task automatic wait_event(input int unsigned pos, input int unsigned limit,
                              input string what);
        int unsigned n;
        bit          seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            n++;
            if (events[pos]) seen = 1'b1;
        end
        if (!seen) begin
            $display("Timeout: no %s event within %0d cycles", what, limit);
            $display("TESTS FAILED");
            $fatal(1, "timeout waiting for %s", what);
        end
    endtask

    task automatic check_passthrough(input int unsigned pos);
        @(negedge clk);
        dma_pe_evt = (pos == EVT_DMA_PE);
        dma_pe_irq = (pos == EVT_DMA_IRQ);
        pf_evt     = (pos == EVT_PF);
        @(negedge clk);
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        pf_evt     = 1'b0;
        check_value("fc_events_o", events, 32'd1 << pos);
        @(negedge clk);
        check_value("fc_events_o", events, '0);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        pdata_t      rdata;
        logic        err;
        pdata_t      wval;
        int unsigned pin;
        int unsigned other_pin;
        int unsigned cmp_val;
        int unsigned t_first;

        rst_n       = 1'b0;
        slow_clk    = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        gpio_in     = '0;
        fetch_valid = 1'b0;
        fetch_en    = 1'b0;
        dma_pe_evt  = 1'b0;
        dma_pe_irq  = 1'b0;
        pf_evt      = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values
        check_value("fc_events_o", events, '0);
        check_value("fc_fetchen_o", fetchen, 0);
        check_value("fc_bootaddr_o", bootaddr, BOOT_ADDR_DEFAULT);
        check_value("gpio_dir_o", gpio_dir, '0);
        check_value("gpio_out_o", gpio_out, '0);
        apb_read(SOC_CTRL_BASE + SOC_INFO_OFFS, rdata, err);
        check_value("soc info", rdata, NB_CORES_INFO);
        apb_read(TIMER_BASE + TIMER_CNT_OFFS, rdata, err);
        check_value("timer count", rdata, 0);

        // Random writes and readbacks
        wval = $random(seed);
        apb_write(GPIO_BASE + GPIO_DIR_OFFS, wval, err);
        check_value("gpio_dir_o", gpio_dir, wval);
        apb_read(GPIO_BASE + GPIO_DIR_OFFS, rdata, err);
        check_value("gpio dir readback", rdata, wval);
        wval = $random(seed);
        apb_write(GPIO_BASE + GPIO_OUT_OFFS, wval, err);
        check_value("gpio_out_o", gpio_out, wval);
        apb_read(GPIO_BASE + GPIO_OUT_OFFS, rdata, err);
        check_value("gpio out readback", rdata, wval);
        wval = $random(seed);
        apb_write(SOC_CTRL_BASE + SOC_BOOT_OFFS, wval, err);
        check_value("fc_bootaddr_o", bootaddr, wval);
        apb_read(SOC_CTRL_BASE + SOC_BOOT_OFFS, rdata, err);
        check_value("boot readback", rdata, wval);

        // Unmapped region and unmapped offsets
        apb_write(32'h0000_5000, $random(seed), err);
        check_value("pslverr_o", err, 1);
        apb_read(32'h0000_5000, rdata, err);
        check_value("pslverr_o", err, 1);
        check_value("prdata_o", rdata, 0);
        apb_read(GPIO_BASE + 32'h20, rdata, err);
        check_value("pslverr_o", err, 0);
        check_value("prdata_o", rdata, 0);
        apb_write(TIMER_BASE + 32'h10, $random(seed), err);
        check_value("pslverr_o", err, 0);
        apb_read(TIMER_BASE + 32'h10, rdata, err);
        check_value("prdata_o", rdata, 0);

        ////////////////////////////////////////
        // GPIO interrupt
        ////////////////////////////////////////
        pin       = $unsigned($random(seed)) % GPIO_NUM;
        other_pin = (pin + 1 + $unsigned($random(seed)) % (GPIO_NUM - 1)) % GPIO_NUM;
        apb_write(GPIO_BASE + GPIO_IEN_OFFS, 32'd1 << pin, err);
        @(negedge clk);
        gpio_in[pin] = 1'b1;
        wait_event(EVT_GPIO, 20, "GPIO");
        apb_read(GPIO_BASE + GPIO_IN_OFFS, rdata, err);
        check_value("gpio input", rdata, 32'd1 << pin);
        apb_read(GPIO_BASE + GPIO_IST_OFFS, rdata, err);
        check_value("gpio status", rdata, 32'd1 << pin);
        apb_read(GPIO_BASE + GPIO_IST_OFFS, rdata, err);
        check_value("gpio status", rdata, 0);
        // Pin without interrupt enable
        gpio_in[other_pin] = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_value("fc_events_o[EVT_GPIO]", events[EVT_GPIO], 0);
        end
        apb_read(GPIO_BASE + GPIO_IST_OFFS, rdata, err);
        check_value("gpio status", rdata, 0);

        ////////////////////////////////////////
        // Timer
        ////////////////////////////////////////
        cmp_val = 3 + $unsigned($random(seed)) % 6;
        apb_write(TIMER_BASE + TIMER_CMP_OFFS, cmp_val, err);
        apb_write(TIMER_BASE + TIMER_CNT_OFFS, 0, err);
        apb_write(TIMER_BASE + TIMER_CTRL_OFFS, 32'd1 << TIMER_EN_BIT, err);
        wait_event(EVT_TIMER, 2 * cmp_val + 10, "timer");
        t_first = cycle_cnt;
        wait_event(EVT_TIMER, 2 * cmp_val + 10, "timer");
        check_value("EVT_TIMER spacing", cycle_cnt - t_first, cmp_val + 1);

        // Reference source with compare 0 gives one pulse per ref rising edge
        apb_write(TIMER_BASE + TIMER_CTRL_OFFS, 0, err);
        apb_write(TIMER_BASE + TIMER_CMP_OFFS, 0, err);
        apb_write(TIMER_BASE + TIMER_CNT_OFFS, 0, err);
        apb_write(TIMER_BASE + TIMER_CTRL_OFFS,
                  (32'd1 << TIMER_EN_BIT) | (32'd1 << TIMER_REF_SRC_BIT), err);
        repeat (2) begin
            @(negedge clk);
            slow_clk = 1'b1;
            wait_event(EVT_REF_EDGE, 10, "reference rise");
            check_value("fc_events_o[EVT_TIMER]", events[EVT_TIMER], 0);
            @(negedge clk);
            check_value("fc_events_o[EVT_TIMER]", events[EVT_TIMER], 1);
            slow_clk = 1'b0;
            wait_event(EVT_REF_EDGE, 10, "reference fall");
            repeat (4) begin
                @(negedge clk);
                check_value("fc_events_o[EVT_TIMER]", events[EVT_TIMER], 0);
            end
        end
        apb_write(TIMER_BASE + TIMER_CTRL_OFFS, 0, err);

        ////////////////////////////////////////
        // Fetch enable and pass-through events
        ////////////////////////////////////////
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_en    = 1'b1;
        @(negedge clk);
        fetch_valid = 1'b0;
        fetch_en    = 1'b0;
        check_value("fc_fetchen_o", fetchen, 1);
        apb_write(SOC_CTRL_BASE + SOC_FETCH_OFFS, 0, err);
        check_value("fc_fetchen_o", fetchen, 0);

        repeat (4) @(negedge clk);
        check_passthrough(EVT_DMA_PE);
        check_passthrough(EVT_DMA_IRQ);
        check_passthrough(EVT_PF);

        repeat (2) @(negedge clk);
        if (u_soc_peripherals.u_props.fail_count != 0) begin
            $display("TESTS FAILED");
            $fatal(1, "%0d bound assertion failures", u_soc_peripherals.u_props.fail_count);
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
